// ==== filelist.f ====
+incdir+verif
source/cpu_bus_pkg.sv
source/bus_addr_decode.sv
source/gcu_op_strobe.sv
source/work_ram16.sv
source/bus_read_result.sv
source/main_bus_top.sv
verif/main_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the main bus testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f filelist.f \
    --top-module main_bus_tb \
    -o main_bus_sim

./obj_dir/main_bus_sim > sim.log 2>&1 || { cat sim.log; echo "simulator exited with an error"; exit 1; }
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation PASSED"

// ==== source/bus_addr_decode.sv ====
module bus_addr_decode import cpu_bus_pkg::*; (
    input  logic         clk96,
    input  logic         reset96,
    input  cpu_bus_req_t req,
    output dev_sel_t     sel,
    output io_port_e     port,
    output logic         prg_cs,
    output logic [18:0]  prg_addr
);

    logic [23:0] byte_addr;
    dev_sel_t    hit;
    io_port_e    port_hit;

    assign byte_addr = {req.addr, 1'b0}; // follows the byte map

    always_comb begin
        hit        = '0;
        hit.rom    = byte_addr <= ROM_LAST;
        hit.ram    = byte_addr[23:16] == RAM_HI8;
        hit.gcu    = byte_addr[23:20] == GCU_HI4;
        hit.palram = byte_addr[23:20] == PAL_HI4;
        hit.io     = byte_addr[23:12] == IO_HI12;
        hit.oki    = byte_addr[23:20] == OKI_HI4;
        hit.ym     = byte_addr[23:20] == YM_HI4;
    end

    always_comb begin
        case (byte_addr[11:0])
            IO_JMPR_OFS: port_hit = JMPR;
            IO_DSWA_OFS: port_hit = DSWA;
            IO_DSWB_OFS: port_hit = DSWB;
            IO_IN1_OFS:  port_hit = IN1;
            IO_IN2_OFS:  port_hit = IN2;
            IO_IN3_OFS:  port_hit = IN3;
            IO_IN4_OFS:  port_hit = IN4;
            IO_SYS_OFS:  port_hit = SYS;
            IO_BANK_OFS: port_hit = OKIBANK;
            IO_COIN_OFS: port_hit = COIN;
            default:     port_hit = NONE;
        endcase
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            sel      <= '0;
            port     <= JMPR;
            prg_cs   <= 1'b0;
            prg_addr <= '0;
        end else if (req.valid) begin
            sel      <= hit;
            port     <= hit.io ? port_hit : JMPR; // zero outside the I/O page
            prg_cs   <= hit.rom;
            prg_addr <= req.addr[19:1];
        end else begin
            sel    <= '0;
            port   <= JMPR;
            prg_cs <= 1'b0;
        end
    end

    // a held request selects at most one device
    a_sel_onehot: assert property (@(posedge clk96) disable iff (reset96)
        req.valid |=> $onehot0(sel));

endmodule

// ==== source/bus_read_result.sv ====
module bus_read_result import cpu_bus_pkg::*; #(
    parameter int ACK_DELAY = 1
) (
    input  logic         clk96,
    input  logic         reset96,
    input  cpu_bus_req_t req,
    input  dev_sel_t     sel,
    input  io_port_e     port,
    input  logic [15:0]  ram_q,
    input  logic [15:0]  pal_q,
    input  logic [15:0]  prg_data,
    input  logic [15:0]  gcu_dout,
    input  logic         prg_ok,
    input  logic         gcu_ack,
    input  cabinet_in_t  cab,
    input  logic         hsync,
    input  logic         vsync,
    input  logic         fblank,
    input  logic         lvbl,
    input  logic [8:0]   vcount,
    input  logic [7:0]   oki_dout,
    input  logic [7:0]   ym_dout,
    output logic [15:0]  rdata,
    output logic         ack,
    output logic         oki_bank
);

    localparam logic [3:0] ACK_CNT = 4'(ACK_DELAY);

    logic [3:0]  cnt;
    logic        pending;   // valid seen last edge, sel now meaningful
    logic [3:0]  gcu_ofs;
    logic        gcu_wait;  // access that needs the GCU's answer
    logic        go;
    logic [7:0]  p1_ctrl, p2_ctrl, p3_ctrl, p4_ctrl;
    logic [7:0]  sys_lo;
    logic [15:0] vid_status;
    logic [15:0] rd_mux;

    // inputs are high active, the game reads them low active
    function automatic logic [5:0] joy_map(input logic [9:0] j);
        return ~{j[5], j[4], j[0], j[1], j[2], j[3]}; // b2 b1 right left down up
    endfunction

    assign gcu_ofs  = {req.addr[3:1], 1'b0};
    assign gcu_wait = sel.gcu && (gcu_op_decode(req.write, gcu_ofs) != '0);

    assign p1_ctrl = {2'b00, joy_map(cab.joy1)};
    assign p2_ctrl = {2'b00, joy_map(cab.joy2)};
    assign p3_ctrl = {1'b0, ~cab.joy3[6], joy_map(cab.joy3)};
    assign p4_ctrl = {1'b0, ~cab.joy4[6], joy_map(cab.joy4)};
    assign sys_lo  = {1'b0, ~cab.start[1], ~cab.start[0], ~cab.coin[1], ~cab.coin[0],
                      ~cab.test, 1'b0, ~cab.service};

    assign vid_status = {~hsync, ~vsync, 5'b11111, ~fblank,
                         vcount[8] ? 8'hFF : vcount[7:0]};

    always_comb begin
        rd_mux = '0;
        if (sel.rom)
            rd_mux = prg_data;
        else if (sel.ram)
            rd_mux = ram_q;
        else if (sel.palram)
            rd_mux = pal_q;
        else if (gcu_wait)
            rd_mux = gcu_dout;
        else if (sel.gcu && gcu_ofs == GCU_STAT_OFS)
            rd_mux = {15'b0, ~lvbl};
        else if (sel.gcu && gcu_ofs == GCU_VSTAT_OFS)
            rd_mux = vid_status;
        else if (sel.oki)
            rd_mux = {2{oki_dout}};
        else if (sel.ym)
            rd_mux = {2{ym_dout}};
        else if (sel.io) begin
            case (port)
                IN1:     rd_mux = {2{p1_ctrl}};
                IN2:     rd_mux = {2{p2_ctrl}};
                IN3:     rd_mux = {2{p3_ctrl}};
                IN4:     rd_mux = {2{p4_ctrl}};
                SYS:     rd_mux = {cab.dipsw_c, sys_lo};
                DSWA:    rd_mux = {2{cab.dipsw_a}};
                DSWB:    rd_mux = {2{cab.dipsw_b}};
                JMPR:    rd_mux = {2{cab.dipsw_c}};
                default: rd_mux = '0; // bank, coin counter, unmapped
            endcase
        end
    end

    // ROM and GCU wait for their device, everything else counts
    assign go = pending && !ack &&
                ((sel.rom && prg_ok) ||
                 (gcu_wait && gcu_ack) ||
                 (!sel.rom && !gcu_wait && cnt == ACK_CNT));

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            pending  <= 1'b0;
            cnt      <= '0;
            ack      <= 1'b0;
            rdata    <= '0;
            oki_bank <= 1'b0;
        end else begin
            pending <= req.valid;
            if (!req.valid) begin
                cnt <= '0;
                ack <= 1'b0;      // release follows the strobe
            end else begin
                if (pending && !ack && cnt != ACK_CNT)
                    cnt <= cnt + 4'd1;
                if (go) begin
                    ack   <= 1'b1;
                    rdata <= req.write ? 16'h0000 : rd_mux;
                    if (sel.io && port == OKIBANK && req.write && req.be[0])
                        oki_bank <= req.wdata[0];
                end
            end
        end
    end

    a_ack_needs_valid: assert property (@(posedge clk96) disable iff (reset96)
        $rose(ack) |-> $past(req.valid));

endmodule

// ==== source/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

    // one 68000-style access, held by the CPU until ack
    typedef struct packed {
        logic        valid;     // address strobe
        logic [23:1] addr;      // word address
        logic        write;
        logic [1:0]  be;        // {upper, lower}
        logic [15:0] wdata;
    } cpu_bus_req_t;

    typedef struct packed {
        logic rom;
        logic ram;
        logic gcu;
        logic palram;
        logic io;
        logic oki;
        logic ym;
    } dev_sel_t;

    typedef struct packed {
        logic select_reg;
        logic write_reg;
        logic write_ram;
        logic read_ram_h;
        logic read_ram_l;
        logic set_ram_ptr;
    } gcu_op_t;

    typedef struct packed {
        logic [9:0] joy1;       // high active, as delivered by the framework
        logic [9:0] joy2;
        logic [9:0] joy3;
        logic [9:0] joy4;
        logic [3:0] start;
        logic [3:0] coin;
        logic       service;
        logic       test;
        logic [7:0] dipsw_a;
        logic [7:0] dipsw_b;
        logic [7:0] dipsw_c;
    } cabinet_in_t;

    typedef enum logic [3:0] {
        JMPR, DSWA, DSWB, IN1, IN2, IN3, IN4, SYS, OKIBANK, COIN, NONE
    } io_port_e;

    // byte address map
    localparam logic [23:0] ROM_LAST = 24'h07_FFFF;
    localparam logic [7:0]  RAM_HI8  = 8'h10;     // 100000-10FFFF
    localparam logic [3:0]  GCU_HI4  = 4'h3;
    localparam logic [3:0]  PAL_HI4  = 4'h4;
    localparam logic [3:0]  YM_HI4   = 4'h5;
    localparam logic [3:0]  OKI_HI4  = 4'h6;
    localparam logic [11:0] IO_HI12  = 12'h700;

    // offsets inside the I/O page
    localparam logic [11:0] IO_JMPR_OFS = 12'h000;
    localparam logic [11:0] IO_DSWA_OFS = 12'h004;
    localparam logic [11:0] IO_DSWB_OFS = 12'h008;
    localparam logic [11:0] IO_IN1_OFS  = 12'h00C;
    localparam logic [11:0] IO_IN2_OFS  = 12'h010;
    localparam logic [11:0] IO_IN3_OFS  = 12'h014;
    localparam logic [11:0] IO_IN4_OFS  = 12'h018;
    localparam logic [11:0] IO_SYS_OFS  = 12'h01C;
    localparam logic [11:0] IO_BANK_OFS = 12'h030;
    localparam logic [11:0] IO_COIN_OFS = 12'h034;

    // GCU registers answered locally, without a strobe
    localparam logic [3:0] GCU_STAT_OFS  = 4'hC;  // vblank flag
    localparam logic [3:0] GCU_VSTAT_OFS = 4'hE;  // sync flags and line count

    // strobe raised by a GCU access at byte offset ofs, zero if none
    function automatic gcu_op_t gcu_op_decode(input logic write, input logic [3:0] ofs);
        gcu_op_t op;
        op = '0;
        if (write) begin
            case (ofs)
                4'h0:       op.set_ram_ptr = 1'b1;
                4'h4, 4'h6: op.write_ram   = 1'b1;
                4'h8:       op.select_reg  = 1'b1;
                4'hC:       op.write_reg   = 1'b1;
                default:    op = '0;
            endcase
        end else begin
            case (ofs)
                4'h4:    op.read_ram_h = 1'b1;
                4'h6:    op.read_ram_l = 1'b1;
                default: op = '0;
            endcase
        end
        return op;
    endfunction

endpackage

// ==== source/gcu_op_strobe.sv ====
module gcu_op_strobe import cpu_bus_pkg::*; (
    input  logic         clk96,
    input  logic         reset96,
    input  cpu_bus_req_t req,
    input  dev_sel_t     sel,
    input  logic         gcu_ack,
    output gcu_op_t      gcu_op
);

    gcu_op_t op_next;
    logic    issued;    // strobe already sent for this access

    assign op_next = gcu_op_decode(req.write, {req.addr[3:1], 1'b0});

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            gcu_op <= '0;
            issued <= 1'b0;
        end else begin
            if (!sel.gcu)
                issued <= 1'b0;   // re-arm between accesses

            if (gcu_ack) begin
                gcu_op <= '0;     // GCU took the operation
            end else if (sel.gcu && !issued) begin
                gcu_op <= op_next;
                issued <= 1'b1;
            end
        end
    end

    // the GCU sees one operation at a time
    a_op_onehot: assert property (@(posedge clk96) disable iff (reset96)
        $onehot0(gcu_op));

endmodule

// ==== source/main_bus_top.sv ====
module main_bus_top import cpu_bus_pkg::*; #(
    parameter int RAM_AW    = 15,
    parameter int PAL_AW    = 11,
    parameter int ACK_DELAY = 1
) (
    input  logic              clk96,
    input  logic              reset96,
    input  cpu_bus_req_t      req,
    output logic [15:0]       rdata,
    output logic              ack,
    output logic [15:0]       wdata_out,
    output logic              prg_cs,
    output logic [18:0]       prg_addr,
    input  logic              prg_ok,
    input  logic [15:0]       prg_data,
    output gcu_op_t           gcu_op,
    input  logic              gcu_ack,
    input  logic [15:0]       gcu_dout,
    input  cabinet_in_t       cab,
    input  logic              hsync,
    input  logic              vsync,
    input  logic              fblank,
    input  logic              lvbl,
    input  logic [8:0]        vcount,
    input  logic [PAL_AW-1:0] pal_addr,
    output logic [15:0]       pal_data,
    output logic              oki_cs,
    output logic              ym_cs,
    input  logic [7:0]        oki_dout,
    input  logic [7:0]        ym_dout,
    output logic              oki_bank
);

    dev_sel_t    sel;
    io_port_e    port;
    logic [1:0]  ram_we;
    logic [1:0]  pal_we;
    logic [15:0] ram_q;
    logic [15:0] pal_q;

    assign ram_we    = {2{sel.ram && req.write}} & req.be;
    assign pal_we    = {2{sel.palram && req.write}} & req.be;
    assign oki_cs    = sel.oki;
    assign ym_cs     = sel.ym;
    assign wdata_out = req.wdata;   // sound chips and GCU share the CPU data bus

    bus_addr_decode u_decode (
        .clk96    (clk96),
        .reset96  (reset96),
        .req      (req),
        .sel      (sel),
        .port     (port),
        .prg_cs   (prg_cs),
        .prg_addr (prg_addr)
    );

    gcu_op_strobe u_gcu_op (
        .clk96   (clk96),
        .reset96 (reset96),
        .req     (req),
        .sel     (sel),
        .gcu_ack (gcu_ack),
        .gcu_op  (gcu_op)
    );

    // work RAM 100000-10FFFF
    work_ram16 #(.RAM_AW(RAM_AW)) u_wram (
        .clk96 (clk96),
        .we    (ram_we),
        .addr0 (req.addr[RAM_AW:1]),
        .addr1 (req.addr[RAM_AW:1]),
        .wdata (req.wdata),
        .q0    (ram_q),
        .q1    ()
    );

    // palette RAM, second port to the video side
    work_ram16 #(.RAM_AW(PAL_AW)) u_palram (
        .clk96 (clk96),
        .we    (pal_we),
        .addr0 (req.addr[PAL_AW:1]),
        .addr1 (pal_addr),
        .wdata (req.wdata),
        .q0    (pal_q),
        .q1    (pal_data)
    );

    bus_read_result #(.ACK_DELAY(ACK_DELAY)) u_result (
        .clk96    (clk96),
        .reset96  (reset96),
        .req      (req),
        .sel      (sel),
        .port     (port),
        .ram_q    (ram_q),
        .pal_q    (pal_q),
        .prg_data (prg_data),
        .gcu_dout (gcu_dout),
        .prg_ok   (prg_ok),
        .gcu_ack  (gcu_ack),
        .cab      (cab),
        .hsync    (hsync),
        .vsync    (vsync),
        .fblank   (fblank),
        .lvbl     (lvbl),
        .vcount   (vcount),
        .oki_dout (oki_dout),
        .ym_dout  (ym_dout),
        .rdata    (rdata),
        .ack      (ack),
        .oki_bank (oki_bank)
    );

endmodule

// ==== source/work_ram16.sv ====
module work_ram16 #(
    parameter int RAM_AW = 15
) (
    input  logic              clk96,
    input  logic [1:0]        we,       // {upper, lower} byte
    input  logic [RAM_AW-1:0] addr0,
    input  logic [RAM_AW-1:0] addr1,
    input  logic [15:0]       wdata,
    output logic [15:0]       q0,
    output logic [15:0]       q1
);

    logic [15:0] mem [0:(2**RAM_AW)-1];

    // port 0, CPU side
    always_ff @(posedge clk96) begin
        if (we[1])
            mem[addr0][15:8] <= wdata[15:8];
        if (we[0])
            mem[addr0][7:0] <= wdata[7:0];
        q0 <= mem[addr0];       // old data on a write cycle
    end

    // port 1, read only
    always_ff @(posedge clk96) begin
        q1 <= mem[addr1];
    end

endmodule

// ==== verif/main_bus_checks.svh ====
`ifndef MAIN_BUS_CHECKS_SVH
`define MAIN_BUS_CHECKS_SVH

int value_errs = 0;     // wrong data or strobe values
int other_errs = 0;     // timing and handshake problems

task automatic check_word(input string name, input logic [15:0] got,
                          input logic [15:0] exp);
    if (got !== exp) begin
        value_errs++;
        $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic check_addr(input string name, input logic [18:0] got,
                          input logic [18:0] exp);
    if (got !== exp) begin
        value_errs++;
        $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic check_ops(input string name, input gcu_op_t got, input gcu_op_t exp);
    if (got !== exp) begin
        value_errs++;
        $display("** Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        value_errs++;
        $display("** Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
    end
endtask

// anything that is not a plain value mismatch
task automatic report_problem(input string what);
    other_errs++;
    $display("** Error at %0d ns: %s", $time, what);
endtask

`endif

// ==== verif/main_bus_tb.sv ====
module main_bus_tb import cpu_bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [1:0]  kind;      // how ack is expected to come back
        logic [23:0] byte_addr;
        logic        write;
        logic [1:0]  be;
        logic [15:0] wdata;
        logic [8:0]  vline;     // vcount during the access
        logic [15:0] exp_rdata;
        gcu_op_t     exp_op;
        logic        exp_bank;  // oki_bank after the access
    } row_t;

    localparam int          RESET_CYCLES = 2;
    localparam logic [15:0] GCU_WORD     = 16'hC0DE;
    localparam logic [1:0]  LOCAL        = 2'd0;
    localparam logic [1:0]  ROM          = 2'd1;
    localparam logic [1:0]  GCU          = 2'd2;

    // strobe order {select_reg, write_reg, write_ram, read_ram_h, read_ram_l, set_ram_ptr}
    localparam gcu_op_t NO_OP   = 6'b000000;
    localparam gcu_op_t OP_SELR = 6'b100000;
    localparam gcu_op_t OP_WREG = 6'b010000;
    localparam gcu_op_t OP_WRAM = 6'b001000;
    localparam gcu_op_t OP_RDH  = 6'b000100;
    localparam gcu_op_t OP_RDL  = 6'b000010;
    localparam gcu_op_t OP_PTR  = 6'b000001;

    logic         clk96 = 1'b0;
    logic         reset96;
    cpu_bus_req_t req;
    logic [15:0]  rdata;
    logic         ack;
    logic [15:0]  wdata_out;
    logic         prg_cs;
    logic [18:0]  prg_addr;
    logic         prg_ok = 1'b0;
    logic [15:0]  prg_data = 16'h0000;
    gcu_op_t      gcu_op;
    logic         gcu_ack = 1'b0;
    logic [15:0]  gcu_dout;
    cabinet_in_t  cab;
    logic         hsync;
    logic         vsync;
    logic         fblank;
    logic         lvbl;
    logic [8:0]   vcount;
    logic [10:0]  pal_addr;
    logic [15:0]  pal_data;
    logic         oki_cs;
    logic         ym_cs;
    logic [7:0]   oki_dout;
    logic [7:0]   ym_dout;
    logic         oki_bank;

    row_t   rows[$];
    integer seed = 32'h7144_365e;
    int     rom_left = -1;      // -1 while prg_cs is low
    int     rom_delay = 0;
    int     gcu_wait_cnt = 0;
    int     cycle_cnt = 0;
    int     cycle_limit = 1000;

    `include "main_bus_checks.svh"

    main_bus_top #(.RAM_AW(15), .PAL_AW(11), .ACK_DELAY(1)) dut0 (
        .clk96 (clk96), .reset96 (reset96), .req (req), .rdata (rdata), .ack (ack),
        .wdata_out (wdata_out), .prg_cs (prg_cs), .prg_addr (prg_addr),
        .prg_ok (prg_ok), .prg_data (prg_data), .gcu_op (gcu_op), .gcu_ack (gcu_ack),
        .gcu_dout (gcu_dout), .cab (cab), .hsync (hsync), .vsync (vsync),
        .fblank (fblank), .lvbl (lvbl), .vcount (vcount), .pal_addr (pal_addr),
        .pal_data (pal_data), .oki_cs (oki_cs), .ym_cs (ym_cs), .oki_dout (oki_dout),
        .ym_dout (ym_dout), .oki_bank (oki_bank)
    );

    always #20 clk96 = ~clk96;

    // program ROM, answers 0 to 3 cycles after chip select with its word address
    always @(negedge clk96) begin
        prg_data <= prg_addr[15:0];
        if (!prg_cs) begin
            prg_ok   <= 1'b0;
            rom_left <= -1;
        end else if (rom_left < 0) begin
            rom_delay = $unsigned($random(seed)) % 4;
            rom_left <= rom_delay;
            prg_ok   <= (rom_delay == 0);
        end else if (rom_left > 0) begin
            rom_left <= rom_left - 1;
            prg_ok   <= (rom_left == 1);
        end
    end

    // GCU takes any strobe after 2 cycles, acks for one cycle
    always @(negedge clk96) begin
        if (gcu_ack) begin
            gcu_ack      <= 1'b0;
            gcu_wait_cnt <= 0;
        end else if (gcu_op != NO_OP) begin
            if (gcu_wait_cnt == 1)
                gcu_ack <= 1'b1;
            else
                gcu_wait_cnt <= gcu_wait_cnt + 1;
        end
    end

    always @(posedge clk96) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: table not finished after %0d cycles", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    function automatic void add_row(input logic [1:0] kind, input logic [23:0] addr,
                                    input logic write, input logic [1:0] be,
                                    input logic [15:0] wdata, input logic [8:0] vline,
                                    input logic [15:0] exp_rdata, input gcu_op_t exp_op,
                                    input logic exp_bank);
        row_t r;
        r = '{kind, addr, write, be, wdata, vline, exp_rdata, exp_op, exp_bank};
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        // work RAM, byte lanes merged
        add_row(LOCAL, 24'h100010, 1'b1, 2'b11, 16'h1234, 9'h0F0, 16'h0000, NO_OP, 1'b0);
        add_row(LOCAL, 24'h100010, 1'b1, 2'b10, 16'hABCD, 9'h0F0, 16'h0000, NO_OP, 1'b0);
        add_row(LOCAL, 24'h100010, 1'b1, 2'b01, 16'h5566, 9'h0F0, 16'h0000, NO_OP, 1'b0);
        add_row(LOCAL, 24'h100010, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'hAB66, NO_OP, 1'b0);
        // palette RAM
        add_row(LOCAL, 24'h400020, 1'b1, 2'b11, 16'h0F0F, 9'h0F0, 16'h0000, NO_OP, 1'b0);
        add_row(LOCAL, 24'h400020, 1'b1, 2'b01, 16'h00A5, 9'h0F0, 16'h0000, NO_OP, 1'b0);
        add_row(LOCAL, 24'h400020, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'h0FA5, NO_OP, 1'b0);
        // program ROM, data is the word address
        add_row(ROM,   24'h001234, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'h091A, NO_OP, 1'b0);
        add_row(ROM,   24'h07FFFE, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'hFFFF, NO_OP, 1'b0);
        add_row(ROM,   24'h02468A, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'h2345, NO_OP, 1'b0);
        // GCU strobes by offset and direction
        add_row(GCU,   24'h300000, 1'b1, 2'b11, 16'h0040, 9'h0F0, 16'h0000, OP_PTR, 1'b0);
        add_row(GCU,   24'h300004, 1'b1, 2'b11, 16'h1111, 9'h0F0, 16'h0000, OP_WRAM, 1'b0);
        add_row(GCU,   24'h300006, 1'b1, 2'b11, 16'h2222, 9'h0F0, 16'h0000, OP_WRAM, 1'b0);
        add_row(GCU,   24'h300008, 1'b1, 2'b11, 16'h0005, 9'h0F0, 16'h0000, OP_SELR, 1'b0);
        add_row(GCU,   24'h30000C, 1'b1, 2'b11, 16'h00AA, 9'h0F0, 16'h0000, OP_WREG, 1'b0);
        add_row(GCU,   24'h300004, 1'b0, 2'b11, 16'h0000, 9'h0F0, GCU_WORD, OP_RDH, 1'b0);
        add_row(GCU,   24'h300006, 1'b0, 2'b11, 16'h0000, 9'h0F0, GCU_WORD, OP_RDL, 1'b0);
        add_row(LOCAL, 24'h300002, 1'b1, 2'b11, 16'h0077, 9'h0F0, 16'h0000, NO_OP, 1'b0);
        // status registers, answered without the GCU
        add_row(LOCAL, 24'h30000C, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'h0001, NO_OP, 1'b0);
        add_row(LOCAL, 24'h30000E, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'h7EF0, NO_OP, 1'b0);
        add_row(LOCAL, 24'h30000E, 1'b0, 2'b11, 16'h0000, 9'h105, 16'h7EFF, NO_OP, 1'b0);
        // cabinet inputs and DIP switches
        add_row(LOCAL, 24'h70000C, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'h2727, NO_OP, 1'b0);
        add_row(LOCAL, 24'h700010, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'h1A1A, NO_OP, 1'b0);
        add_row(LOCAL, 24'h700014, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'h3D3D, NO_OP, 1'b0);
        add_row(LOCAL, 24'h700018, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'h7F7F, NO_OP, 1'b0);
        add_row(LOCAL, 24'h70001C, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'h814C, NO_OP, 1'b0);
        add_row(LOCAL, 24'h700004, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'h5A5A, NO_OP, 1'b0);
        add_row(LOCAL, 24'h700008, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'hC3C3, NO_OP, 1'b0);
        add_row(LOCAL, 24'h700000, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'h8181, NO_OP, 1'b0);
        // sound chips and an empty hole in the map
        add_row(LOCAL, 24'h600000, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'h3C3C, NO_OP, 1'b0);
        add_row(LOCAL, 24'h500000, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'h9696, NO_OP, 1'b0);
        add_row(LOCAL, 24'h200000, 1'b0, 2'b11, 16'h0000, 9'h0F0, 16'h0000, NO_OP, 1'b0);
        // sample bank, only the lower byte lane latches it
        add_row(LOCAL, 24'h700030, 1'b1, 2'b01, 16'h0001, 9'h0F0, 16'h0000, NO_OP, 1'b1);
        add_row(LOCAL, 24'h700030, 1'b1, 2'b10, 16'h0000, 9'h0F0, 16'h0000, NO_OP, 1'b1);
        add_row(LOCAL, 24'h700030, 1'b1, 2'b11, 16'h0000, 9'h0F0, 16'h0000, NO_OP, 1'b0);
    endfunction

    // one CPU access, held until ack, then released
    task automatic run_access(input row_t r);
        int      cycles;
        gcu_op_t op_seen;
        logic    acked;
        cycles    = 0;
        op_seen   = NO_OP;
        acked     = 1'b0;
        vcount    = r.vline;
        req.addr  = r.byte_addr[23:1];
        req.write = r.write;
        req.be    = r.be;
        req.wdata = r.wdata;
        req.valid = 1'b1;
        while (!acked) begin
            @(negedge clk96);
            cycles++;
            op_seen = op_seen | gcu_op;   // strobes raised while waiting
            acked   = ack;
        end
        check_word("rdata", rdata, r.exp_rdata);
        check_ops("gcu_op strobes", op_seen, r.exp_op);
        check_bit("oki_bank", oki_bank, r.exp_bank);
        check_word("wdata_out", wdata_out, r.wdata);
        check_bit("prg_cs", prg_cs, r.kind == ROM);
        check_bit("oki_cs", oki_cs, r.byte_addr[23:20] == 4'h6);   // 600000-6FFFFF
        check_bit("ym_cs", ym_cs, r.byte_addr[23:20] == 4'h5);     // 500000-5FFFFF
        if (r.kind == LOCAL && cycles != 3)
            report_problem($sformatf("access to %h acked %0d cycles after valid, not 2",
                                     r.byte_addr, cycles - 1));
        if (r.kind == ROM) begin
            check_bit("prg_ok", prg_ok, 1'b1);
            check_addr("prg_addr", prg_addr, r.byte_addr[19:1]);
            if (cycles != rom_delay + 2)
                report_problem($sformatf("ROM ack came %0d cycles after prg_ok, not 1",
                                         cycles - 1 - rom_delay));
        end
        if (r.kind == GCU)
            check_ops("gcu_op", gcu_op, NO_OP);   // cleared by gcu_ack
        req.valid = 1'b0;
        @(negedge clk96);
        check_bit("ack", ack, 1'b0);
        @(negedge clk96);
    endtask

    initial begin
        reset96       = 1'b1;
        req           = '0;
        gcu_dout      = GCU_WORD;
        cab           = '0;
        cab.joy1      = 10'h011;   // right, button 1
        cab.joy2      = 10'h02A;   // left, up, button 2
        cab.joy3      = 10'h044;   // down, button 3
        cab.joy4      = 10'h000;
        cab.start     = 4'b0001;
        cab.coin      = 4'b0010;
        cab.service   = 1'b1;
        cab.test      = 1'b0;
        cab.dipsw_a   = 8'h5A;
        cab.dipsw_b   = 8'hC3;
        cab.dipsw_c   = 8'h81;
        hsync         = 1'b1;
        vsync         = 1'b0;
        fblank        = 1'b1;
        lvbl          = 1'b0;      // in vertical blank
        vcount        = 9'h0F0;
        pal_addr      = '0;
        oki_dout      = 8'h3C;
        ym_dout       = 8'h96;
        build_table();
        cycle_limit = rows.size() * 10 + RESET_CYCLES;

        repeat (RESET_CYCLES) @(negedge clk96);
        reset96 = 1'b0;
        check_bit("ack", ack, 1'b0);
        check_ops("gcu_op", gcu_op, NO_OP);
        check_bit("oki_bank", oki_bank, 1'b0);
        check_bit("prg_cs", prg_cs, 1'b0);
        check_word("rdata", rdata, 16'h0000);

        foreach (rows[i])
            run_access(rows[i]);

        // video side reads the palette word written above
        pal_addr = 11'h010;
        @(negedge clk96);
        check_word("pal_data", pal_data, 16'h0FA5);

        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule
